// File: verilog/enigmaAlphabetPkg.sv
// Letter width, index and character types, ASCII constants and conversion helpers
package enigmaAlphabetPkg;

    localparam int letterWidth  = 5;
    localparam int alphabetSize = 26;

    typedef logic [letterWidth-1:0] letterIdx;
    typedef logic [7:0]             asciiChar;

    localparam asciiChar asciiBase = "A";
    localparam asciiChar asciiLast = "Z";

    // Uppercase A to Z only
    function automatic logic isLetterChar(input asciiChar c);
        return (c >= asciiBase) && (c <= asciiLast);
    endfunction

    // Only meaningful for letters
    function automatic letterIdx charToIdx(input asciiChar c);
        asciiChar offset;
        offset = c - asciiBase;
        return offset[letterWidth-1:0];
    endfunction

    function automatic asciiChar idxToChar(input letterIdx idx);
        asciiChar wide;
        wide = asciiChar'(idx);
        return asciiBase + wide;
    endfunction

endpackage

// File: verilog/enigmaWiringPkg.sv
// Rotor, reflector and plugboard wiring tables with their lookup functions
package enigmaWiringPkg;

    import enigmaAlphabetPkg::*;

    localparam int maxRotors = 3;

    // Row k is the forward table of rotor k, entry i is where contact i leads
    localparam letterIdx rotorWiring [maxRotors][alphabetSize] = '{
        '{ 7, 12, 21, 17,  0,  2, 22, 20, 23, 18,  9, 25, 15,
           3, 14, 13, 11,  8,  4, 10,  6,  5, 19, 16, 24,  1},
        '{19,  4,  7,  6, 12, 17,  8,  5,  2,  0,  1, 20, 25,
           9, 14, 22, 24, 18, 15, 13,  3, 10, 21, 16, 11, 23},
        '{19,  0,  6,  1, 15,  2, 18,  3, 16,  4, 20,  5, 21,
          13, 25,  7, 24,  8, 23,  9, 22, 11, 17, 10, 14, 12}
    };

    // Thirteen swapped pairs, no letter maps to itself
    localparam letterIdx reflectorWiring [alphabetSize] = '{
        24, 17, 20,  7, 16, 18, 11,  3, 15, 23, 13,  6, 14,
        10, 12,  8,  4,  1,  5, 25,  2, 22, 21,  9,  0, 19
    };

    // Ten swapped pairs, the other six letters unplugged
    localparam letterIdx plugWiring [alphabetSize] = '{
         4, 10, 12,  5,  0,  3, 11, 16, 21, 25,  1,  6,  2,
        22, 24, 15,  7, 17, 18, 19, 20,  8, 13, 23, 14,  9
    };

    function automatic letterIdx rotorForward(input int stage, input letterIdx idx);
        return rotorWiring[stage][idx];
    endfunction

    // Search for the contact that leads to idx
    function automatic letterIdx rotorInverse(input int stage, input letterIdx idx);
        letterIdx result;
        result = '0;
        for (int i = 0; i < alphabetSize; i++) begin
            if (rotorWiring[stage][i] == idx) begin
                result = letterIdx'(i);
            end
        end
        return result;
    endfunction

    function automatic letterIdx reflect(input letterIdx idx);
        return reflectorWiring[idx];
    endfunction

    // Involutive, so the same table serves both directions
    function automatic letterIdx plug(input letterIdx idx);
        return plugWiring[idx];
    endfunction

endpackage

// File: verilog/letterIngress.sv
// Letter check, ASCII to index conversion, forward plugboard and first register stage
module letterIngress
    import enigmaAlphabetPkg::*;
    import enigmaWiringPkg::*;
(
    input  logic     load,
    input  logic     rstN,
    input  logic     inStrobe,
    input  asciiChar inChar,
    output logic     stepStrobe,
    output logic     passStrobe,
    output letterIdx fwdIdx,
    output asciiChar rawChar
);

    logic     isLetter;
    logic     takeLetter;
    logic     takeOther;
    letterIdx plainIdx;

    assign isLetter   = isLetterChar(inChar);
    assign takeLetter = inStrobe && isLetter;
    assign takeOther  = inStrobe && !isLetter;
    assign plainIdx   = charToIdx(inChar);

    always_ff @(posedge load or negedge rstN) begin
        if (!rstN) begin
            stepStrobe <= 1'b0;
            passStrobe <= 1'b0;
        end else begin
            stepStrobe <= takeLetter;
            passStrobe <= takeOther;
        end
    end

    // Plugboard applied before the register
    always_ff @(posedge load) begin
        if (takeLetter) begin
            fwdIdx <= plug(plainIdx);
        end
    end

    // Non-letters bypass the cipher path
    always_ff @(posedge load) begin
        if (takeOther) begin
            rawChar <= inChar;
        end
    end

endmodule

// File: verilog/rotorStage.sv
// One rotor's forward and backward substitution at its current position
module rotorStage
    import enigmaAlphabetPkg::*;
    import enigmaWiringPkg::*;
#(
    parameter int stageIdx = 0
) (
    input  letterIdx position,
    input  letterIdx fwdIn,
    input  letterIdx bwdIn,
    output letterIdx fwdOut,
    output letterIdx bwdOut
);

    letterIdx fwdEntry;
    letterIdx bwdEntry;

    function automatic letterIdx addMod(input letterIdx a, input letterIdx b);
        logic [letterWidth:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= (letterWidth + 1)'(alphabetSize)) begin
            sum = sum - (letterWidth + 1)'(alphabetSize);
        end
        return sum[letterWidth-1:0];
    endfunction

    function automatic letterIdx subMod(input letterIdx a, input letterIdx b);
        logic [letterWidth:0] diff;
        diff = {1'b0, a} + (letterWidth + 1)'(alphabetSize) - {1'b0, b};
        if (diff >= (letterWidth + 1)'(alphabetSize)) begin
            diff = diff - (letterWidth + 1)'(alphabetSize);
        end
        return diff[letterWidth-1:0];
    endfunction

    // Rotate into the rotor frame, substitute, rotate back out
    assign fwdEntry = addMod(fwdIn, position);
    assign fwdOut   = subMod(rotorForward(stageIdx, fwdEntry), position);

    assign bwdEntry = addMod(bwdIn, position);
    assign bwdOut   = subMod(rotorInverse(stageIdx, bwdEntry), position);

endmodule

// File: verilog/rotorStepper.sv
// Rotor position registers with start position load and odometer stepping
module rotorStepper
    import enigmaAlphabetPkg::*;
#(
    parameter int rotorCount = 3
) (
    input  logic                      load,
    input  logic                      rstN,
    input  logic                      keyLoad,
    input  letterIdx [rotorCount-1:0] startPos,
    input  logic                      stepStrobe,
    output letterIdx [rotorCount-1:0] position
);

    letterIdx [rotorCount-1:0] posReg;
    letterIdx [rotorCount-1:0] stepped;
    logic                      keyLoadSeen;
    logic                      advance;

    // Rotor 0 always moves, a wrap carries into the next one
    always_comb begin
        logic carry;
        carry = 1'b1;
        for (int k = 0; k < rotorCount; k++) begin
            if (!carry) begin
                stepped[k] = posReg[k];
            end else if (posReg[k] == letterIdx'(alphabetSize - 1)) begin
                stepped[k] = '0;
            end else begin
                stepped[k] = posReg[k] + 1'b1;
                carry      = 1'b0;
            end
        end
    end

    // A letter loaded together with the key is not stepped
    assign advance = stepStrobe && !keyLoadSeen;

    // Letter in flight sees its step before the commit edge
    assign position = advance ? stepped : posReg;

    always_ff @(posedge load or negedge rstN) begin
        if (!rstN) begin
            posReg      <= '0;
            keyLoadSeen <= 1'b0;
        end else begin
            keyLoadSeen <= keyLoad;
            if (keyLoad) begin
                posReg <= startPos;
            end else if (advance) begin
                posReg <= stepped;
            end
        end
    end

endmodule

// File: verilog/letterEgress.sv
// Reflector, backward plugboard, index to ASCII conversion and output register
module letterEgress
    import enigmaAlphabetPkg::*;
    import enigmaWiringPkg::*;
(
    input  logic     load,
    input  logic     rstN,
    input  logic     stepStrobe,
    input  logic     passStrobe,
    input  asciiChar rawChar,
    input  letterIdx reflIn,
    input  letterIdx bwdIn,
    output letterIdx reflOut,
    output logic     outStrobe,
    output asciiChar outChar
);

    asciiChar cipherChar;

    // Turnaround at the end of the forward chain
    assign reflOut = reflect(reflIn);

    assign cipherChar = idxToChar(plug(bwdIn));

    always_ff @(posedge load or negedge rstN) begin
        if (!rstN) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= stepStrobe || passStrobe;
        end
    end

    // At most one of the two strobes is high
    always_ff @(posedge load) begin
        if (stepStrobe) begin
            outChar <= cipherChar;
        end else if (passStrobe) begin
            outChar <= rawChar;
        end
    end

endmodule

// File: verilog/enigmaTop.sv
// Top level of the letter cipher: ingress, rotor chain, stepper and egress
module enigmaTop
    import enigmaAlphabetPkg::*;
#(
    parameter int rotorCount = 3
) (
    input  logic                      load,
    input  logic                      rstN,
    input  logic                      inStrobe,
    input  asciiChar                  inChar,
    input  logic                      keyLoad,
    input  letterIdx [rotorCount-1:0] startPos,
    output logic                      outStrobe,
    output asciiChar                  outChar
);

    logic                      stepStrobe;
    logic                      passStrobe;
    asciiChar                  rawChar;
    letterIdx [rotorCount-1:0] position;

    // Entry k feeds stage k forward, entry k+1 feeds it backward
    letterIdx [rotorCount:0]   fwdChain;
    letterIdx [rotorCount:0]   bwdChain;

    letterIngress ingress (
        .load       (load),
        .rstN       (rstN),
        .inStrobe   (inStrobe),
        .inChar     (inChar),
        .stepStrobe (stepStrobe),
        .passStrobe (passStrobe),
        .fwdIdx     (fwdChain[0]),
        .rawChar    (rawChar)
    );

    rotorStepper #(
        .rotorCount (rotorCount)
    ) stepper (
        .load       (load),
        .rstN       (rstN),
        .keyLoad    (keyLoad),
        .startPos   (startPos),
        .stepStrobe (stepStrobe),
        .position   (position)
    );

    for (genvar k = 0; k < rotorCount; k++) begin : rotorChain
        rotorStage #(
            .stageIdx (k)
        ) stage (
            .position (position[k]),
            .fwdIn    (fwdChain[k]),
            .bwdIn    (bwdChain[k+1]),
            .fwdOut   (fwdChain[k+1]),
            .bwdOut   (bwdChain[k])
        );
    end

    letterEgress egress (
        .load       (load),
        .rstN       (rstN),
        .stepStrobe (stepStrobe),
        .passStrobe (passStrobe),
        .rawChar    (rawChar),
        .reflIn     (fwdChain[rotorCount]),
        .bwdIn      (bwdChain[0]),
        .reflOut    (bwdChain[rotorCount]),
        .outStrobe  (outStrobe),
        .outChar    (outChar)
    );

endmodule

// File: verification/enigma_assertions.sv
// Bound concurrent assertions on the output strobe latency and the rotor positions
module enigmaAssertions
    import enigmaAlphabetPkg::*;
#(
    parameter int rotorCount = 3
) (
    input logic                      load,
    input logic                      rstN,
    input logic                      inStrobe,
    input logic                      outStrobe,
    input letterIdx [rotorCount-1:0] position
);
    timeunit 1ns;
    timeprecision 1ps;

    int failureCount = 0;

    quietInReset: assert property (@(posedge load) !rstN |-> !outStrobe)
        else begin
            $error("outStrobe high while reset is asserted");
            failureCount++;
        end

    // Two register stages between input and output
    strobeLatency: assert property (@(posedge load) disable iff (!rstN)
        outStrobe == $past(inStrobe, 2))
        else begin
            $error("outStrobe does not follow inStrobe two edges later");
            failureCount++;
        end

    for (genvar k = 0; k < rotorCount; k++) begin : positionRange
        inRange: assert property (@(posedge load) disable iff (!rstN)
            position[k] < letterIdx'(alphabetSize))
            else begin
                $error("rotor %0d position left the alphabet", k);
                failureCount++;
            end
    end

endmodule

bind enigmaTop enigmaAssertions #(
    .rotorCount (rotorCount)
) propertyChecks (
    .load      (load),
    .rstN      (rstN),
    .inStrobe  (inStrobe),
    .outStrobe (outStrobe),
    .position  (position)
);

// File: verification/enigmaModel.svh
// Reference model of the cipher: inverse rotor tables, odometer stepping and letter encipherment
`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

// Needs rotorCount and both cipher packages visible where it is included
typedef letterIdx [rotorCount-1:0] rotorPos;

int inverseWiring [maxRotors][alphabetSize];

function automatic void buildInverseTables();
    for (int k = 0; k < maxRotors; k++) begin
        for (int i = 0; i < alphabetSize; i++) begin
            inverseWiring[k][rotorWiring[k][i]] = i;
        end
    end
endfunction

function automatic logic modelIsLetter(input asciiChar c);
    return (c >= 8'h41) && (c <= 8'h5A);
endfunction

// Odometer, rotor 0 first, carry only on a wrap to 0
function automatic rotorPos modelStep(input rotorPos pos);
    rotorPos next;
    int      v;
    next = pos;
    for (int k = 0; k < rotorCount; k++) begin
        v = (int'(next[k]) + 1) % alphabetSize;
        next[k] = letterIdx'(v);
        if (v != 0) begin
            break;
        end
    end
    return next;
endfunction

function automatic asciiChar modelEncipher(input asciiChar c, input rotorPos pos);
    int x;
    int p;
    if (!modelIsLetter(c)) begin
        return c;
    end
    x = int'(plugWiring[letterIdx'(int'(c) - int'(asciiBase))]);
    for (int k = 0; k < rotorCount; k++) begin
        p = int'(pos[k]);
        x = int'(rotorWiring[k][letterIdx'((x + p) % alphabetSize)]);
        x = (x - p + alphabetSize) % alphabetSize;
    end
    x = int'(reflectorWiring[letterIdx'(x)]);
    // Back out through the rotors in reverse order
    for (int k = rotorCount - 1; k >= 0; k--) begin
        p = int'(pos[k]);
        x = inverseWiring[k][letterIdx'((x + p) % alphabetSize)];
        x = (x - p + alphabetSize) % alphabetSize;
    end
    x = int'(plugWiring[letterIdx'(x)]);
    return asciiChar'(x + int'(asciiBase));
endfunction

`endif

// File: verification/tbEnigma.sv
// Testbench for the letter cipher with clock, reset, random stimulus, model checks and summary
module tbEnigma
    import enigmaAlphabetPkg::*;
    import enigmaWiringPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int rotorCount  = 3;
    localparam int streamLen   = 500;
    localparam int recipLen    = 200;
    localparam int odometerLen = 700;
    localparam int passLen     = 120;
    localparam int loadTrials  = 30;
    localparam int totalChars  = streamLen + 2 * recipLen + odometerLen + passLen
                               + 2 * loadTrials;
    localparam int cycleLimit  = 3 * totalChars + 200;

    `include "enigmaModel.svh"

    logic     load;
    logic     rstN;
    logic     inStrobe;
    asciiChar inChar;
    logic     keyLoad;
    rotorPos  startPos;
    logic     outStrobe;
    asciiChar outChar;

    asciiChar expectedChars[$];
    asciiChar gotChars[$];
    rotorPos  modelPos;
    string    testName;
    int       errorCount = 0;
    int       checkCount = 0;
    int       testCount  = 0;
    int       testErrors = 0;
    int       testChecks = 0;
    int       cycleCount = 0;

    enigmaTop #(
        .rotorCount (rotorCount)
    ) dut (
        .load      (load),
        .rstN      (rstN),
        .inStrobe  (inStrobe),
        .inChar    (inChar),
        .keyLoad   (keyLoad),
        .startPos  (startPos),
        .outStrobe (outStrobe),
        .outChar   (outChar)
    );

    always #5 load = ~load;

    // Ends the run when the tests stall
    initial begin : watchdog
        while (cycleCount < cycleLimit) begin
            @(posedge load);
            cycleCount++;
        end
        $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
        $display("** FAIL **");
        $finish;
    end

    // Compare each strobed output with the oldest prediction
    always @(negedge load) begin : compareOutput
        asciiChar want;
        if (outStrobe) begin
            gotChars.push_back(outChar);
            if (expectedChars.size() == 0) begin
                $display("Output strobe seen with no character pending, outChar %h", outChar);
                errorCount++;
                testErrors++;
            end else begin
                want = expectedChars.pop_front();
                checkCount++;
                testChecks++;
                if (outChar !== want) begin
                    $display("FAILED outChar: expected %h, got %h", want, outChar);
                    errorCount++;
                    testErrors++;
                end
            end
        end
    end

    function automatic asciiChar randomLetter();
        return asciiBase + asciiChar'($urandom % alphabetSize);
    endfunction

    function automatic asciiChar nonLetterChar();
        asciiChar c;
        do begin
            c = asciiChar'($urandom);
        end while (c >= "A" && c <= "Z");
        return c;
    endfunction

    function automatic rotorPos randomKey();
        rotorPos key;
        for (int i = 0; i < rotorCount; i++) begin
            key[i] = letterIdx'($urandom % alphabetSize);
        end
        return key;
    endfunction

    task automatic startTest(input string name);
        testCount++;
        testName   = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic reportTest();
        $display("Test %0d %s: %0d checks, %0d errors", testCount, testName,
                 testChecks, testErrors);
    endtask

    // Predict with the key and step that this character will see
    task automatic sendChar(input asciiChar c, input logic withLoad, input rotorPos start);
        @(posedge load);
        inStrobe <= 1'b1;
        inChar   <= c;
        keyLoad  <= withLoad;
        startPos <= start;
        if (withLoad) begin
            modelPos = start;
        end else if (modelIsLetter(c)) begin
            modelPos = modelStep(modelPos);
        end
        expectedChars.push_back(modelEncipher(c, modelPos));
    endtask

    task automatic loadKey(input rotorPos start);
        @(posedge load);
        inStrobe <= 1'b0;
        keyLoad  <= 1'b1;
        startPos <= start;
        modelPos = start;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge load);
            inStrobe <= 1'b0;
            keyLoad  <= 1'b0;
        end
    endtask

    task automatic drainOutputs();
        idleCycles(1);
        while (expectedChars.size() != 0) begin
            @(negedge load);
        end
        repeat (3) @(negedge load);
    endtask

    task automatic checkQuiet();
        testChecks++;
        checkCount++;
        if (outStrobe !== 1'b0) begin
            $display("FAILED outStrobe: expected %h, got %h", 1'b0, outStrobe);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkPositions(input rotorPos want);
        testChecks++;
        checkCount++;
        if (dut.position !== want) begin
            $display("FAILED position: expected %h, got %h", want, dut.position);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic applyReset();
        startTest("reset");
        repeat (10) begin
            @(negedge load);
            checkQuiet();
        end
        @(posedge load);
        rstN <= 1'b1;
        repeat (20) begin
            @(negedge load);
            checkQuiet();
        end
        checkPositions('0);
        reportTest();
    endtask

    task automatic streamRandomLetters();
        startTest("random stream");
        for (int i = 0; i < streamLen; i++) begin
            if (i % 125 == 0) begin
                loadKey(randomKey());
            end
            sendChar(randomLetter(), 1'b0, '0);
            if ($urandom % 2 == 1) begin
                idleCycles(1 + $urandom % 2);
            end
        end
        drainOutputs();
        reportTest();
    endtask

    task automatic roundTripCipher();
        rotorPos  key;
        asciiChar plain[$];
        asciiChar cipher[$];
        startTest("reciprocity");
        key = randomKey();
        for (int i = 0; i < recipLen; i++) begin
            plain.push_back(randomLetter());
        end
        gotChars.delete();
        loadKey(key);
        foreach (plain[i]) begin
            sendChar(plain[i], 1'b0, key);
        end
        drainOutputs();
        cipher = gotChars;
        if (cipher.size() != plain.size()) begin
            $display("Ciphertext has %0d characters instead of %0d", cipher.size(), recipLen);
            errorCount++;
            testErrors++;
        end else begin
            foreach (plain[i]) begin
                testChecks++;
                checkCount++;
                if (cipher[i] == plain[i]) begin
                    $display("Letter %h enciphered to itself at index %0d", plain[i], i);
                    errorCount++;
                    testErrors++;
                end
            end
        end
        // Same key on the ciphertext must give the plaintext back
        gotChars.delete();
        loadKey(key);
        foreach (cipher[i]) begin
            sendChar(cipher[i], 1'b0, key);
        end
        drainOutputs();
        if (gotChars.size() != plain.size()) begin
            $display("Decipher returned %0d characters instead of %0d", gotChars.size(),
                     recipLen);
            errorCount++;
            testErrors++;
        end else begin
            foreach (plain[i]) begin
                testChecks++;
                checkCount++;
                if (gotChars[i] !== plain[i]) begin
                    $display("FAILED outChar: expected %h, got %h", plain[i], gotChars[i]);
                    errorCount++;
                    testErrors++;
                end
            end
        end
        reportTest();
    endtask

    task automatic sweepOdometer();
        rotorPos key;
        startTest("odometer");
        key    = randomKey();
        key[0] = letterIdx'(alphabetSize - 1);
        key[1] = letterIdx'(alphabetSize - 1);
        loadKey(key);
        for (int i = 0; i < odometerLen; i++) begin
            sendChar(randomLetter(), 1'b0, key);
        end
        drainOutputs();
        checkPositions(modelPos);
        reportTest();
    endtask

    task automatic mixNonLetters();
        asciiChar c;
        startTest("pass-through");
        loadKey(randomKey());
        for (int i = 0; i < passLen; i++) begin
            c = ($urandom % 5 < 2) ? nonLetterChar() : randomLetter();
            sendChar(c, 1'b0, '0);
            if ($urandom % 4 == 0) begin
                idleCycles(1);
            end
        end
        drainOutputs();
        checkPositions(modelPos);
        reportTest();
    endtask

    task automatic loadWithLetter();
        rotorPos key;
        startTest("load priority");
        for (int i = 0; i < loadTrials; i++) begin
            key = randomKey();
            sendChar(randomLetter(), 1'b1, key);
            sendChar(randomLetter(), 1'b0, key);
        end
        drainOutputs();
        reportTest();
    endtask

    initial begin
        void'($urandom(19104));
        load     = 1'b0;
        rstN     = 1'b0;
        inStrobe = 1'b0;
        inChar   = '0;
        keyLoad  = 1'b0;
        startPos = '0;
        modelPos = '0;
        buildInverseTables();

        applyReset();
        streamRandomLetters();
        roundTripCipher();
        sweepOdometer();
        mixNonLetters();
        loadWithLetter();

        errorCount += dut.propertyChecks.failureCount;
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 testCount, checkCount, errorCount, dut.propertyChecks.failureCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+verification
verilog/enigmaAlphabetPkg.sv
verilog/enigmaWiringPkg.sv
verilog/letterIngress.sv
verilog/rotorStage.sv
verilog/rotorStepper.sv
verilog/letterEgress.sv
verilog/enigmaTop.sv
verification/enigma_assertions.sv
verification/tbEnigma.sv

// File: Makefile
# Verilator flow for the letter cipher; all variables can be overridden

VERILATOR ?= verilator
TOP       ?= tbEnigma
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, not the exit code of the binary
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
